// File: logic/io_board_pkg.sv
package io_board_pkg;

	// ====================================================================
	// board dimensions
	// ====================================================================

	localparam int num_gpio = 2;    // header ports, one bus word each
	localparam int gpio_width = 32; // header cut down from 36 pins
	localparam int key_count = 2;   // push-buttons, active low

	// ====================================================================
	// timing defaults, in clk cycles
	// ====================================================================

	localparam int debounce_cycles = 16;  // stable samples before a key flips
	localparam int long_hold_cycles = 64; // press length that means cold reset

	// reset request fsm
	typedef enum logic [1:0] {
		RST_IDLE = 2'd0, // key released
		RST_HELD = 2'd1, // pressed, counting
		RST_LONG = 2'd2  // cold already sent, wait for release
	} rst_state_t;

endpackage

// File: logic/hm_bus_pkg.sv
package hm_bus_pkg;

	// ====================================================================
	// host bus widths
	// ====================================================================

	localparam int bus_width = 32;  // data word
	localparam int addr_width = 8;  // word address, byte lanes already stripped

	// ====================================================================
	// address layout
	// ====================================================================

	// low bits pick the register inside a port
	localparam int reg_sel_width = 2;
	// everything above is the port index
	localparam int port_idx_width = addr_width - reg_sel_width;

	// register opcodes, one per low address value
	typedef enum logic [reg_sel_width-1:0] {
		REG_DATA = 2'd0, // output data, r/w
		REG_DDR  = 2'd1, // direction, 1 = drive, r/w
		REG_PINS = 2'd2, // synchronized pin level, read only
		REG_NONE = 2'd3  // unused slot, reads zero
	} reg_sel_t;

endpackage

// File: logic/gpio_reg_if.sv
interface gpio_reg_if #(
	parameter int NUM_GPIO = io_board_pkg::num_gpio
);
	import hm_bus_pkg::*;

	// at least one select bit even for a single port
	localparam int PORT_W = (NUM_GPIO > 1) ? $clog2(NUM_GPIO) : 1;

	logic                 wr_en;    // one-cycle write pulse, already qualified
	logic [PORT_W-1:0]    port_sel;
	reg_sel_t             reg_sel;
	logic [bus_width-1:0] wdata;
	logic [bus_width-1:0] rdata;    // comb from port_sel / reg_sel

	modport master (output wr_en, port_sel, reg_sel, wdata, input rdata);
	modport bank (input wr_en, port_sel, reg_sel, wdata, output rdata);

endinterface

// File: logic/hm_bus_port.sv
module hm_bus_port #(
	parameter int NUM_GPIO = io_board_pkg::num_gpio
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             chip_select,
	input  logic                             bus_write,
	input  logic                             bus_read,
	input  logic [hm_bus_pkg::addr_width-1:0] bus_address,
	input  logic [hm_bus_pkg::bus_width-1:0]  bus_wdata,
	output logic [hm_bus_pkg::bus_width-1:0]  bus_rdata,
	output logic                             read_valid,
	gpio_reg_if.master                       regs
);
	import hm_bus_pkg::*;

	logic [port_idx_width-1:0] port_idx;
	reg_sel_t                  reg_sel;
	logic                      port_hit;     // index inside the bank
	logic                      rd_req;
	logic                      rd_hit;       // read that returns bank data
	logic                      rd_stage;     // wait state valid
	logic [bus_width-1:0]      rdata_stage;  // data held over the wait state

	// ====================================================================
	// address decode and strobe qualify
	// ====================================================================

	assign port_idx = bus_address[addr_width-1:reg_sel_width];
	assign reg_sel = reg_sel_t'(bus_address[reg_sel_width-1:0]);
	assign port_hit = 32'(port_idx) < NUM_GPIO;

	// only data and ddr are writable, everything else is dropped here
	assign regs.wr_en = chip_select && bus_write && port_hit
		&& (reg_sel == REG_DATA || reg_sel == REG_DDR);
	assign regs.port_sel = port_idx[regs.PORT_W-1:0]; // in range once port_hit
	assign regs.reg_sel = reg_sel;
	assign regs.wdata = bus_wdata;

	assign rd_req = chip_select && bus_read;
	assign rd_hit = port_hit && reg_sel != REG_NONE; // misses read zero

	// ====================================================================
	// read pipe, strobe edge then one wait state
	// ====================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_stage <= 1'b0;
			read_valid <= 1'b0;
		end else begin
			rd_stage <= rd_req;
			read_valid <= rd_stage; // high for exactly one cycle per read
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req) begin
			rdata_stage <= rd_hit ? regs.rdata : '0;
		end
		if (rd_stage) begin
			bus_rdata <= rdata_stage; // holds until the next read
		end
	end

endmodule

// File: logic/gpio_port_bank.sv
module gpio_port_bank #(
	parameter int NUM_GPIO = io_board_pkg::num_gpio,
	parameter int GPIO_WIDTH = io_board_pkg::gpio_width
) (
	input  logic                           clk,
	input  logic                           reset,
	gpio_reg_if.bank                       regs,
	input  logic [NUM_GPIO*GPIO_WIDTH-1:0] gpio_in,
	output logic [NUM_GPIO*GPIO_WIDTH-1:0] gpio_out,
	output logic [NUM_GPIO*GPIO_WIDTH-1:0] gpio_oe
);
	import hm_bus_pkg::*;

	logic [GPIO_WIDTH-1:0] data_q [NUM_GPIO];   // output latch per port
	logic [GPIO_WIDTH-1:0] ddr_q [NUM_GPIO];    // 1 = pin driven
	logic [GPIO_WIDTH-1:0] pin_meta [NUM_GPIO]; // first sync flop
	logic [GPIO_WIDTH-1:0] pin_sync [NUM_GPIO]; // safe to read
	logic [GPIO_WIDTH-1:0] rd_word;

	// ====================================================================
	// data and direction registers
	// ====================================================================

	// wr_en arrives qualified, so no range check here
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < NUM_GPIO; p++) begin
				data_q[p] <= '0;
				ddr_q[p] <= '0; // all pins inputs out of reset
			end
		end else if (regs.wr_en) begin
			case (regs.reg_sel)
				REG_DATA: data_q[regs.port_sel] <= regs.wdata[GPIO_WIDTH-1:0];
				REG_DDR:  ddr_q[regs.port_sel] <= regs.wdata[GPIO_WIDTH-1:0];
				default:  ;
			endcase
		end
	end

	// ====================================================================
	// pin input synchronizers
	// ====================================================================

	always_ff @(posedge clk) begin
		for (int p = 0; p < NUM_GPIO; p++) begin
			pin_meta[p] <= gpio_in[p*GPIO_WIDTH +: GPIO_WIDTH];
			pin_sync[p] <= pin_meta[p];
		end
	end

	// flatten back onto the header vectors
	for (genvar p = 0; p < NUM_GPIO; p++) begin : g_pins
		assign gpio_out[p*GPIO_WIDTH +: GPIO_WIDTH] = data_q[p];
		assign gpio_oe[p*GPIO_WIDTH +: GPIO_WIDTH] = ddr_q[p];
	end

	// read mux, bus port registers it
	always_comb begin
		case (regs.reg_sel)
			REG_DATA: rd_word = data_q[regs.port_sel];
			REG_DDR:  rd_word = ddr_q[regs.port_sel];
			REG_PINS: rd_word = pin_sync[regs.port_sel];
			default:  rd_word = '0;
		endcase
	end

	assign regs.rdata = bus_width'(rd_word); // zero extend narrow ports

endmodule

// File: logic/key_debouncer.sv
module key_debouncer #(
	parameter int DEBOUNCE_CYCLES = io_board_pkg::debounce_cycles
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [io_board_pkg::key_count-1:0] key,
	output logic [io_board_pkg::key_count-1:0] key_debounced
);
	import io_board_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [key_count-1:0] key_meta;                // buttons are async
	logic [key_count-1:0] key_sync;
	logic [CNT_W-1:0]     stable_cnt [key_count];  // samples at the new level

	always_ff @(posedge clk) begin
		if (reset) begin
			key_meta <= '1;
			key_sync <= '1;
			key_debounced <= '1; // released
			for (int k = 0; k < key_count; k++) begin
				stable_cnt[k] <= '0;
			end
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
			for (int k = 0; k < key_count; k++) begin
				if (key_sync[k] == key_debounced[k]) begin
					stable_cnt[k] <= '0; // glitch over, start again
				end else if (stable_cnt[k] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					key_debounced[k] <= key_sync[k];
					stable_cnt[k] <= '0;
				end else begin
					stable_cnt[k] <= stable_cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/reset_request_gen.sv
module reset_request_gen #(
	parameter int LONG_HOLD_CYCLES = io_board_pkg::long_hold_cycles
) (
	input  logic clk,
	input  logic reset,
	input  logic key_pressed,    // debounced, active high here
	output logic hps_warm_reset, // one-cycle pulse
	output logic hps_cold_reset  // one-cycle pulse
);
	import io_board_pkg::*;

	localparam int CNT_W = $clog2(LONG_HOLD_CYCLES + 1);

	rst_state_t       state;
	logic [CNT_W-1:0] hold_cnt; // pressed cycles so far

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RST_IDLE;
			hold_cnt <= '0;
			hps_warm_reset <= 1'b0;
			hps_cold_reset <= 1'b0;
		end else begin
			hps_warm_reset <= 1'b0; // pulses by default
			hps_cold_reset <= 1'b0;
			case (state)
				RST_IDLE: begin
					if (key_pressed) begin
						state <= RST_HELD;
						hold_cnt <= CNT_W'(1); // this cycle counts
					end
				end
				RST_HELD: begin
					if (!key_pressed) begin
						hps_warm_reset <= 1'b1; // short press
						state <= RST_IDLE;
					end else if (hold_cnt == CNT_W'(LONG_HOLD_CYCLES - 1)) begin
						hps_cold_reset <= 1'b1; // long press, fire now
						state <= RST_LONG;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				RST_LONG: begin
					if (!key_pressed) begin
						state <= RST_IDLE; // release is silent
					end
				end
				default: state <= RST_IDLE;
			endcase
		end
	end

endmodule

// File: logic/de0_nano_io_top.sv
module de0_nano_io_top #(
	parameter int NUM_GPIO = io_board_pkg::num_gpio,
	parameter int GPIO_WIDTH = io_board_pkg::gpio_width,
	parameter int DEBOUNCE_CYCLES = io_board_pkg::debounce_cycles,
	parameter int LONG_HOLD_CYCLES = io_board_pkg::long_hold_cycles
) (
	input  logic                               clk,
	input  logic                               reset,
	// host bus
	input  logic                               chip_select,
	input  logic                               bus_write,
	input  logic                               bus_read,
	input  logic [hm_bus_pkg::addr_width-1:0]  bus_address,
	input  logic [hm_bus_pkg::bus_width-1:0]   bus_wdata,
	output logic [hm_bus_pkg::bus_width-1:0]   bus_rdata,
	output logic                               read_valid,
	// header pins, split in / out / oe
	input  logic [NUM_GPIO*GPIO_WIDTH-1:0]     gpio_in,
	output logic [NUM_GPIO*GPIO_WIDTH-1:0]     gpio_out,
	output logic [NUM_GPIO*GPIO_WIDTH-1:0]     gpio_oe,
	// buttons and processor reset requests
	input  logic [io_board_pkg::key_count-1:0] key,
	output logic [io_board_pkg::key_count-1:0] key_debounced,
	output logic                               hps_warm_reset,
	output logic                               hps_cold_reset
);

	// ====================================================================
	// host bus to gpio registers
	// ====================================================================

	gpio_reg_if #(.NUM_GPIO(NUM_GPIO)) gpio_regs ();

	hm_bus_port #(.NUM_GPIO(NUM_GPIO)) hm_bus_port_inst (
		.clk         (clk),
		.reset       (reset),
		.chip_select (chip_select),
		.bus_write   (bus_write),
		.bus_read    (bus_read),
		.bus_address (bus_address),
		.bus_wdata   (bus_wdata),
		.bus_rdata   (bus_rdata),
		.read_valid  (read_valid),
		.regs        (gpio_regs)
	);

	gpio_port_bank #(
		.NUM_GPIO   (NUM_GPIO),
		.GPIO_WIDTH (GPIO_WIDTH)
	) gpio_port_bank_inst (
		.clk      (clk),
		.reset    (reset),
		.regs     (gpio_regs),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

	// ====================================================================
	// keys and reset requests
	// ====================================================================

	key_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key_debouncer_inst (
		.clk           (clk),
		.reset         (reset),
		.key           (key),
		.key_debounced (key_debounced)
	);

	reset_request_gen #(.LONG_HOLD_CYCLES(LONG_HOLD_CYCLES)) reset_request_gen_inst (
		.clk            (clk),
		.reset          (reset),
		.key_pressed    (!key_debounced[0]), // key 0 is active low
		.hps_warm_reset (hps_warm_reset),
		.hps_cold_reset (hps_cold_reset)
	);

endmodule

// File: test/de0_nano_io_asserts.sv
module de0_nano_io_asserts (
	input logic                               clk,
	input logic                               reset,
	input logic                               chip_select,
	input logic                               bus_write,
	input logic                               bus_read,
	input logic                               read_valid,
	input logic [io_board_pkg::key_count-1:0] key_debounced,
	input logic                               hps_warm_reset,
	input logic                               hps_cold_reset
);

	int fail_count = 0; // summed into the testbench totals

	task automatic count_failure(input string what);
		fail_count++;
		$error("%s", what);
	endtask

	// ====================================================================
	// host bus
	// ====================================================================

	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(chip_select && bus_write && bus_read))
		else count_failure("read and write strobes high together");

	a_read_wait: assert property (@(posedge clk) disable iff (reset)
		chip_select && bus_read |-> ##2 read_valid)
		else count_failure("read_valid missing one wait state after the strobe");

	a_valid_source: assert property (@(posedge clk) disable iff (reset)
		read_valid |-> $past(chip_select && bus_read, 2))
		else count_failure("read_valid without a read strobe two edges back");

	// ====================================================================
	// reset requests from key 0
	// ====================================================================

	// warm only right after a debounced release, single cycle
	a_warm_pulse: assert property (@(posedge clk) disable iff (reset)
		hps_warm_reset |-> (!hps_cold_reset && key_debounced[0]
		&& $past(!key_debounced[0], 2)) ##1 !hps_warm_reset)
		else count_failure("hps_warm_reset pulse out of place");

	a_cold_pulse: assert property (@(posedge clk) disable iff (reset)
		hps_cold_reset |-> !key_debounced[0] ##1 !hps_cold_reset)
		else count_failure("hps_cold_reset pulse out of place");

endmodule

bind de0_nano_io_top de0_nano_io_asserts asserts_inst (.*);

// File: test/de0_nano_io_tb.sv
module de0_nano_io_tb;
	import hm_bus_pkg::*;

	localparam int num_gpio = 2;
	localparam int gpio_width = 32;
	localparam int debounce_len = 16;
	localparam int short_press = 30;
	localparam int long_press = 100;
	// expected run length in cycles, the watchdog allows twice that
	localparam int bus_cycles = 200;                  // round trip, pins, misses
	localparam int key_cycles = 9 * (debounce_len + 12) + short_press + long_press;
	localparam int watchdog_time = 8 * 2 * (bus_cycles + key_cycles);

	logic                               clk = 1'b0;
	logic                               reset = 1'b1;
	logic                               chip_select = 1'b0;
	logic                               bus_write = 1'b0;
	logic                               bus_read = 1'b0;
	logic [addr_width-1:0]              bus_address = '0;
	logic [bus_width-1:0]               bus_wdata = '0;
	logic [bus_width-1:0]               bus_rdata;
	logic                               read_valid;
	logic [num_gpio*gpio_width-1:0]     gpio_in = '0;
	logic [num_gpio*gpio_width-1:0]     gpio_out;
	logic [num_gpio*gpio_width-1:0]     gpio_oe;
	logic [io_board_pkg::key_count-1:0] key = '1;      // released
	logic [io_board_pkg::key_count-1:0] key_debounced;
	logic                               hps_warm_reset;
	logic                               hps_cold_reset;

	logic [31:0]                    lcg_state = 32'd31;
	logic [31:0]                    shadow_data [num_gpio]; // what the registers should hold
	logic [31:0]                    shadow_ddr [num_gpio];
	logic [num_gpio*gpio_width-1:0] pin_pattern = '0;      // level held on gpio_in
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int tests = 0;
	int warm_count = 0;
	int cold_count = 0;
	int asrt_fails;

	always #4 clk = ~clk;

	de0_nano_io_top #(
		.DEBOUNCE_CYCLES  (debounce_len),
		.LONG_HOLD_CYCLES (64)
	) de0_nano_io_top_inst (.*);

	always @(negedge clk) begin
		if (hps_warm_reset) warm_count++;
		if (hps_cold_reset) cold_count++;
	end

	// ====================================================================
	// helpers
	// ====================================================================

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic fail(input string what);
		$display("failure at %0t: %s", $time, what);
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d, %s, finished with %0d errors", tests, name, test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	// one bus write, shadow follows the register map, pins compared after the edge
	task automatic write_word(input logic cs, input int port, input reg_sel_t sel,
		input logic [31:0] data);
		@(posedge clk);
		chip_select <= cs;
		bus_write <= 1'b1;
		bus_address <= {port_idx_width'(port), sel};
		bus_wdata <= data;
		@(posedge clk); // register loads here
		chip_select <= 1'b0;
		bus_write <= 1'b0;
		if (cs && port < num_gpio && sel == REG_DATA) shadow_data[port] = data;
		if (cs && port < num_gpio && sel == REG_DDR) shadow_ddr[port] = data;
		@(negedge clk);
		for (int p = 0; p < num_gpio; p++) begin
			check($sformatf("gpio_out[%0d]", p), shadow_data[p],
				gpio_out[p*gpio_width +: gpio_width]);
			check($sformatf("gpio_oe[%0d]", p), shadow_ddr[p],
				gpio_oe[p*gpio_width +: gpio_width]);
		end
	endtask

	task automatic read_word(input int port, input reg_sel_t sel);
		logic [31:0] exp;
		int waited;
		exp = '0; // misses and REG_NONE
		if (port < num_gpio && sel == REG_DATA) exp = shadow_data[port];
		if (port < num_gpio && sel == REG_DDR) exp = shadow_ddr[port];
		if (port < num_gpio && sel == REG_PINS) exp = pin_pattern[port*gpio_width +: gpio_width];
		@(posedge clk);
		chip_select <= 1'b1;
		bus_read <= 1'b1;
		bus_address <= {port_idx_width'(port), sel};
		@(posedge clk); // strobe taken
		chip_select <= 1'b0;
		bus_read <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!read_valid && waited < 8);
		if (read_valid) check($sformatf("bus_rdata port %0d %s", port, sel.name()), exp, bus_rdata);
		else fail($sformatf("no read_valid for a read of port %0d %s", port, sel.name()));
	endtask

	task automatic wait_key(input int idx, input logic level);
		int waited;
		waited = 0;
		while (key_debounced[idx] !== level && waited < debounce_len + 8) begin
			@(negedge clk);
			waited++;
		end
		if (key_debounced[idx] !== level) fail($sformatf("key_debounced[%0d] never settled", idx));
	endtask

	// short low pulse on key 1, debounced level must stay released
	task automatic glitch_key1(input int len);
		@(posedge clk);
		key[1] <= 1'b0;
		repeat (len) @(posedge clk);
		key[1] <= 1'b1;
		repeat (debounce_len + 4) begin
			@(negedge clk);
			check("key_debounced[1]", 32'd1, 32'(key_debounced[1]));
		end
	endtask

	// hold key 0 for about len raw cycles, release, let the pulses out
	task automatic press_key0(input int len);
		warm_count = 0;
		cold_count = 0;
		@(posedge clk);
		key[0] <= 1'b0;
		wait_key(0, 1'b0);
		repeat (len - debounce_len) @(posedge clk);
		key[0] <= 1'b1;
		wait_key(0, 1'b1);
		repeat (4) @(negedge clk);
	endtask

	// ====================================================================
	// test sequence
	// ====================================================================

	initial begin
		for (int p = 0; p < num_gpio; p++) begin
			shadow_data[p] = '0;
			shadow_ddr[p] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		for (int p = 0; p < num_gpio; p++) begin
			check($sformatf("gpio_out[%0d]", p), 32'd0, gpio_out[p*gpio_width +: gpio_width]);
			check($sformatf("gpio_oe[%0d]", p), 32'd0, gpio_oe[p*gpio_width +: gpio_width]);
		end
		check("read_valid", 32'd0, 32'(read_valid));
		check("hps_warm_reset", 32'd0, 32'(hps_warm_reset));
		check("hps_cold_reset", 32'd0, 32'(hps_cold_reset));
		check("key_debounced", 32'd3, 32'(key_debounced));
		finish_test("reset state");

		repeat (2) begin
			for (int p = 0; p < num_gpio; p++) begin
				write_word(1'b1, p, REG_DATA, next_random());
				write_word(1'b1, p, REG_DDR, next_random());
			end
			for (int p = 0; p < num_gpio; p++) begin
				read_word(p, REG_DATA);
				read_word(p, REG_DDR);
			end
		end
		finish_test("register round trip");

		@(posedge clk);
		pin_pattern = {next_random(), next_random()};
		gpio_in <= pin_pattern;
		repeat (3) @(posedge clk); // through the synchronizer
		for (int p = 0; p < num_gpio; p++) read_word(p, REG_PINS);
		write_word(1'b1, 0, REG_PINS, next_random());        // read only
		write_word(1'b1, num_gpio, REG_DATA, next_random()); // no such port
		write_word(1'b0, 1, REG_DDR, next_random());         // chip select low
		write_word(1'b1, 1, REG_NONE, next_random());
		read_word(0, REG_NONE);
		read_word(num_gpio, REG_DATA);
		read_word(0, REG_DATA);
		read_word(1, REG_DDR);
		finish_test("pins, ignored accesses and misses");

		glitch_key1(4);
		glitch_key1(9);
		glitch_key1(debounce_len - 1);
		@(posedge clk);
		key[1] <= 1'b0; // held until it gets through
		wait_key(1, 1'b0);
		@(posedge clk);
		key[1] <= 1'b1;
		wait_key(1, 1'b1);
		finish_test("debounce");

		press_key0(short_press);
		check("hps_warm_reset pulses", 32'd1, warm_count);
		check("hps_cold_reset pulses", 32'd0, cold_count);
		press_key0(long_press);
		check("hps_warm_reset pulses", 32'd0, warm_count);
		check("hps_cold_reset pulses", 32'd1, cold_count);
		finish_test("reset requests");

		asrt_fails = de0_nano_io_top_inst.asserts_inst.fail_count;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("watchdog ran out at %0t, a test hung", $time);
		$display("Errors found");
		$finish;
	end

endmodule

// File: src.f
logic/io_board_pkg.sv
logic/hm_bus_pkg.sv
logic/gpio_reg_if.sv
logic/hm_bus_port.sv
logic/gpio_port_bank.sv
logic/key_debouncer.sv
logic/reset_request_gen.sv
logic/de0_nano_io_top.sv
test/de0_nano_io_asserts.sv
test/de0_nano_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then search the log for the failure line
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module de0_nano_io_tb -f src.f -Mdir obj_dir \
	|| { echo "build failed"; exit 1; }
./obj_dir/Vde0_nano_io_tb +verilator+error+limit+1000 2>&1 | tee sim.log \
	|| { echo "simulation exited abnormally"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
